// File: list.f
+incdir+rtl
rtl/geofence_pkg.sv
rtl/isqrt.sv
rtl/point_buffer.sv
rtl/geofence_ctrl.sv
rtl/angular_sort.sv
rtl/polygon_area.sv
rtl/heron_area.sv
rtl/geofence.sv
sim/geofence_properties.sv
sim/geofence_tb.sv

// File: rtl/angular_sort.sv
`timescale 1ns/1ps
`include "geofence_params.svh"

module angular_sort import geofence_pkg::*; (
    input  logic   clk,
    input  logic   reset,
    input  logic   sort_start,
    input  coord_t xs [`GF_POINTS],
    input  coord_t ys [`GF_POINTS],
    output pidx_t  order [`GF_POINTS],
    output logic   sort_done
);

    localparam pidx_t LAST = pidx_t'(`GF_POINTS - 1);

    logic  busy_q;
    pidx_t i_q;
    pidx_t j_q;
    pidx_t neg_q;
    vec_t  dix;
    vec_t  diy;
    vec_t  djx;
    vec_t  djy;
    logic signed [2*`GF_COORD_W+2:0] xprod;
    logic  neg;
    pidx_t pos;

    // vectors from point 0
    assign dix = $signed({1'b0, xs[i_q]}) - $signed({1'b0, xs[0]});
    assign diy = $signed({1'b0, ys[i_q]}) - $signed({1'b0, ys[0]});
    assign djx = $signed({1'b0, xs[j_q]}) - $signed({1'b0, xs[0]});
    assign djy = $signed({1'b0, ys[j_q]}) - $signed({1'b0, ys[0]});

    assign xprod = dix * djy - djx * diy;
    assign neg   = xprod[2*`GF_COORD_W+2];

    // pair with itself gives zero, so 25 pairs cost nothing extra
    assign pos       = neg_q + pidx_t'(neg) + 1'b1;
    assign sort_done = busy_q && (i_q == LAST) && (j_q == LAST);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            busy_q <= 1'b0;
            i_q    <= '0;
            j_q    <= '0;
            neg_q  <= '0;
        end else if (sort_start) begin
            busy_q <= 1'b1;
            i_q    <= pidx_t'(1);
            j_q    <= pidx_t'(1);
            neg_q  <= '0;
        end else if (busy_q) begin
            if (j_q == LAST) begin
                j_q   <= pidx_t'(1);
                i_q   <= i_q + 1'b1;
                neg_q <= '0;
                if (i_q == LAST) begin
                    busy_q <= 1'b0;
                end
            end else begin
                j_q   <= j_q + 1'b1;
                neg_q <= neg_q + pidx_t'(neg);
            end
        end
    end

    // rank of point i is final on its last pair
    always_ff @(posedge clk) begin
        if (sort_start) begin
            order[0] <= '0;
        end else if (busy_q && j_q == LAST) begin
            order[pos] <= i_q;
        end
    end

endmodule

// File: rtl/geofence.sv
`timescale 1ns/1ps
`include "geofence_params.svh"

module geofence import geofence_pkg::*; (
    input  logic   clk,
    input  logic   reset,
    input  coord_t x,
    input  coord_t y,
    input  dist_t  r,
    output logic   valid,
    output logic   is_inside
);

    coord_t xs [`GF_POINTS];
    coord_t ys [`GF_POINTS];
    dist_t  rs [`GF_POINTS];
    pidx_t  order [`GF_POINTS];
    logic   capture;
    logic   loaded;
    logic   sort_start;
    logic   sort_done;
    logic   area_start;
    logic   poly_done;
    logic   heron_done;
    area_t  poly_area;
    area_t  tri_area;

    point_buffer u_buffer (
        .clk     (clk),
        .reset   (reset),
        .capture (capture),
        .x       (x),
        .y       (y),
        .r       (r),
        .xs      (xs),
        .ys      (ys),
        .rs      (rs),
        .loaded  (loaded)
    );

    geofence_ctrl u_ctrl (
        .clk        (clk),
        .reset      (reset),
        .loaded     (loaded),
        .sort_done  (sort_done),
        .poly_done  (poly_done),
        .heron_done (heron_done),
        .poly_area  (poly_area),
        .tri_area   (tri_area),
        .capture    (capture),
        .sort_start (sort_start),
        .area_start (area_start),
        .valid      (valid),
        .is_inside  (is_inside)
    );

    angular_sort u_sort (
        .clk        (clk),
        .reset      (reset),
        .sort_start (sort_start),
        .xs         (xs),
        .ys         (ys),
        .order      (order),
        .sort_done  (sort_done)
    );

    polygon_area u_poly (
        .clk        (clk),
        .reset      (reset),
        .area_start (area_start),
        .xs         (xs),
        .ys         (ys),
        .order      (order),
        .poly_area  (poly_area),
        .poly_done  (poly_done)
    );

    heron_area u_heron (
        .clk        (clk),
        .reset      (reset),
        .area_start (area_start),
        .xs         (xs),
        .ys         (ys),
        .rs         (rs),
        .order      (order),
        .tri_area   (tri_area),
        .heron_done (heron_done)
    );

endmodule

// File: rtl/geofence_ctrl.sv
`timescale 1ns/1ps

module geofence_ctrl import geofence_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  logic  loaded,
    input  logic  sort_done,
    input  logic  poly_done,
    input  logic  heron_done,
    input  area_t poly_area,
    input  area_t tri_area,
    output logic  capture,
    output logic  sort_start,
    output logic  area_start,
    output logic  valid,
    output logic  is_inside
);

    ctrl_state_t state_q;
    ctrl_state_t state_d;
    logic        poly_seen_q;
    logic        heron_seen_q;
    logic        both_seen;
    logic        inside_q;

    assign both_seen = poly_seen_q && heron_seen_q;

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE:    state_d = READ;
            READ:    if (loaded) state_d = SORT;
            SORT:    if (sort_done) state_d = AREA;
            AREA:    if (both_seen) state_d = FINISH;
            FINISH:  state_d = IDLE;
            default: state_d = IDLE;
        endcase
    end

    // point 0 is sampled on the edge that ends IDLE
    assign capture    = (state_q == IDLE) || (state_q == READ);
    assign sort_start = (state_q == READ) && loaded;
    assign area_start = (state_q == SORT) && sort_done;
    assign valid      = (state_q == FINISH);
    assign is_inside  = inside_q;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state_q      <= IDLE;
            poly_seen_q  <= 1'b0;
            heron_seen_q <= 1'b0;
            inside_q     <= 1'b0;
        end else begin
            state_q      <= state_d;
            // sticky until the next area start
            poly_seen_q  <= area_start ? 1'b0 : (poly_seen_q || poly_done);
            heron_seen_q <= area_start ? 1'b0 : (heron_seen_q || heron_done);
            inside_q     <= (state_q == AREA && both_seen) ? (tri_area < poly_area) : 1'b0;
        end
    end

endmodule

// File: rtl/geofence_params.svh
`ifndef GEOFENCE_PARAMS_SVH
`define GEOFENCE_PARAMS_SVH

// sensor points per fence
`define GF_POINTS   6

// coordinate and distance widths
`define GF_COORD_W  10
`define GF_DIST_W   11

// radicand holds the square of a root
`define GF_SQ_W     22

`define GF_AREA_W   26

// index into the point arrays
`define GF_IDX_W    3

`endif

// File: rtl/geofence_pkg.sv
`include "geofence_params.svh"

package geofence_pkg;

    typedef logic [`GF_COORD_W-1:0] coord_t;

    // distance or square root
    typedef logic [`GF_DIST_W-1:0] dist_t;

    // difference of two coordinates, one extra bit for the sign
    typedef logic signed [`GF_COORD_W:0] vec_t;

    typedef logic [`GF_SQ_W-1:0] sq_t;

    typedef logic [`GF_AREA_W-1:0] area_t;

    typedef logic [`GF_IDX_W-1:0] pidx_t;

    // top level phases
    typedef enum logic [2:0] {
        IDLE,
        READ,
        SORT,
        AREA,
        FINISH
    } ctrl_state_t;

endpackage

// File: rtl/heron_area.sv
`timescale 1ns/1ps
`include "geofence_params.svh"

module heron_area import geofence_pkg::*; (
    input  logic   clk,
    input  logic   reset,
    input  logic   area_start,
    input  coord_t xs [`GF_POINTS],
    input  coord_t ys [`GF_POINTS],
    input  dist_t  rs [`GF_POINTS],
    input  pidx_t  order [`GF_POINTS],
    output area_t  tri_area,
    output logic   heron_done
);

    localparam pidx_t LAST_EDGE = pidx_t'(`GF_POINTS - 1);
    localparam pidx_t LAST_STEP = pidx_t'(`GF_POINTS + 1);

    typedef enum logic [1:0] {
        H_IDLE,
        H_LAUNCH,
        H_WAIT
    } heron_state_t;

    heron_state_t state_q;
    pidx_t  step_q;
    pidx_t  len_e;
    pidx_t  fac_e;
    pidx_t  len_a;
    pidx_t  len_b;
    pidx_t  fac_a;
    pidx_t  fac_b;
    area_t  acc_q;
    logic   launch;
    logic   len_start;
    logic   fac_start;
    logic   len_done;
    logic   t1_done;
    logic   t2_done;
    dist_t  c_root;
    dist_t  t1_root;
    dist_t  t2_root;
    vec_t   dx;
    vec_t   dy;
    logic signed [2*`GF_COORD_W+2:0] len_sq;
    logic [`GF_DIST_W+1:0] perim;
    logic signed [`GF_DIST_W+2:0] s;
    logic signed [`GF_DIST_W+2:0] s_c;
    logic signed [`GF_DIST_W+2:0] s_a;
    logic signed [`GF_DIST_W+2:0] s_b;
    logic signed [2*`GF_DIST_W+5:0] f1;
    logic signed [2*`GF_DIST_W+5:0] f2;
    sq_t    len_rad;
    sq_t    t1_rad;
    sq_t    t2_rad;

    // length root of edge n runs beside the factor roots of edge n-1
    assign len_e = step_q;
    assign fac_e = step_q - 1'b1;
    assign len_a = order[len_e];
    assign len_b = order[(len_e == LAST_EDGE) ? pidx_t'(0) : len_e + 1'b1];
    assign fac_a = order[fac_e];
    assign fac_b = order[(fac_e == LAST_EDGE) ? pidx_t'(0) : fac_e + 1'b1];

    assign dx      = $signed({1'b0, xs[len_a]}) - $signed({1'b0, xs[len_b]});
    assign dy      = $signed({1'b0, ys[len_a]}) - $signed({1'b0, ys[len_b]});
    assign len_sq  = dx * dx + dy * dy;
    assign len_rad = sq_t'(len_sq);

    // c_root still holds the finished edge length here
    assign perim = c_root + rs[fac_a] + rs[fac_b];
    assign s     = $signed({2'b0, perim[`GF_DIST_W+1:1]});
    assign s_c   = s - $signed({3'b0, c_root});
    assign s_a   = s - $signed({3'b0, rs[fac_a]});
    assign s_b   = s - $signed({3'b0, rs[fac_b]});
    assign f1    = s * s_c;
    assign f2    = s_a * s_b;

    // negative factors contribute no area
    assign t1_rad = f1[2*`GF_DIST_W+5] ? '0 : sq_t'(f1);
    assign t2_rad = f2[2*`GF_DIST_W+5] ? '0 : sq_t'(f2);

    assign launch     = (state_q == H_LAUNCH);
    assign len_start  = launch && (step_q < pidx_t'(`GF_POINTS));
    assign fac_start  = launch && (step_q != '0) && (step_q < LAST_STEP);
    assign heron_done = launch && (step_q == LAST_STEP);
    assign tri_area   = acc_q;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state_q <= H_IDLE;
            step_q  <= '0;
        end else begin
            case (state_q)
                H_IDLE: begin
                    if (area_start) begin
                        state_q <= H_LAUNCH;
                        step_q  <= '0;
                    end
                end
                H_LAUNCH: begin
                    state_q <= heron_done ? H_IDLE : H_WAIT;
                    step_q  <= step_q + 1'b1;
                end
                H_WAIT: begin
                    if (len_done || (t1_done && t2_done)) begin
                        state_q <= H_LAUNCH;
                    end
                end
                default: state_q <= H_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (area_start) begin
            acc_q <= '0;
        end else if (launch && step_q >= pidx_t'(2)) begin
            acc_q <= acc_q + t1_root * t2_root;
        end
    end

    isqrt u_len (
        .clk      (clk),
        .reset    (reset),
        .start    (len_start),
        .radicand (len_rad),
        .root     (c_root),
        .done     (len_done)
    );

    isqrt u_fac1 (
        .clk      (clk),
        .reset    (reset),
        .start    (fac_start),
        .radicand (t1_rad),
        .root     (t1_root),
        .done     (t1_done)
    );

    isqrt u_fac2 (
        .clk      (clk),
        .reset    (reset),
        .start    (fac_start),
        .radicand (t2_rad),
        .root     (t2_root),
        .done     (t2_done)
    );

endmodule

// File: rtl/isqrt.sv
`timescale 1ns/1ps
`include "geofence_params.svh"

module isqrt import geofence_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  logic  start,
    input  sq_t   radicand,
    output dist_t root,
    output logic  done
);

    localparam int CNT_W = $clog2(`GF_DIST_W);

    logic             busy_q;
    logic [CNT_W-1:0] cnt_q;
    sq_t              rad_q;
    dist_t            root_q;
    logic [`GF_DIST_W+2:0] rem_q;
    logic [`GF_DIST_W+2:0] rem_sh;
    logic [`GF_DIST_W+2:0] trial;
    logic             fits;

    // bring down the next two radicand bits
    assign rem_sh = {rem_q[`GF_DIST_W:0], rad_q[`GF_SQ_W-1 -: 2]};
    assign trial  = {1'b0, root_q, 2'b01};
    assign fits   = (rem_sh >= trial);

    assign done = busy_q && (cnt_q == CNT_W'(`GF_DIST_W - 1));
    assign root = root_q;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            busy_q <= 1'b0;
            cnt_q  <= '0;
        end else if (start) begin
            busy_q <= 1'b1;
            cnt_q  <= '0;
        end else if (busy_q) begin
            busy_q <= !done;
            cnt_q  <= cnt_q + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            rad_q  <= radicand;
            rem_q  <= '0;
            root_q <= '0;
        end else if (busy_q) begin
            rad_q  <= rad_q << 2;
            rem_q  <= fits ? rem_sh - trial : rem_sh;
            root_q <= {root_q[`GF_DIST_W-2:0], fits};
        end
    end

endmodule

// File: rtl/point_buffer.sv
`timescale 1ns/1ps
`include "geofence_params.svh"

module point_buffer import geofence_pkg::*; (
    input  logic   clk,
    input  logic   reset,
    input  logic   capture,
    input  coord_t x,
    input  coord_t y,
    input  dist_t  r,
    output coord_t xs [`GF_POINTS],
    output coord_t ys [`GF_POINTS],
    output dist_t  rs [`GF_POINTS],
    output logic   loaded
);

    pidx_t widx_q;
    logic  last_slot;

    assign last_slot = (widx_q == pidx_t'(`GF_POINTS - 1));
    assign loaded    = capture && last_slot;

    // write index wraps after the sixth point
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            widx_q <= '0;
        end else if (capture) begin
            widx_q <= last_slot ? pidx_t'(0) : widx_q + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            xs[widx_q] <= x;
            ys[widx_q] <= y;
            rs[widx_q] <= r;
        end
    end

endmodule

// File: rtl/polygon_area.sv
`timescale 1ns/1ps
`include "geofence_params.svh"

module polygon_area import geofence_pkg::*; (
    input  logic   clk,
    input  logic   reset,
    input  logic   area_start,
    input  coord_t xs [`GF_POINTS],
    input  coord_t ys [`GF_POINTS],
    input  pidx_t  order [`GF_POINTS],
    output area_t  poly_area,
    output logic   poly_done
);

    localparam pidx_t LAST = pidx_t'(`GF_POINTS - 1);

    logic  busy_q;
    pidx_t k_q;
    pidx_t k_next;
    pidx_t pa;
    pidx_t pb;
    logic [2*`GF_COORD_W-1:0] fwd;
    logic [2*`GF_COORD_W-1:0] bwd;
    logic signed [`GF_AREA_W-1:0] term;
    logic signed [`GF_AREA_W-1:0] acc_q;
    area_t mag;

    // edge from sorted position k to k+1, closing back to 0
    assign k_next = (k_q == LAST) ? pidx_t'(0) : k_q + 1'b1;
    assign pa     = order[k_q];
    assign pb     = order[k_next];

    assign fwd  = xs[pa] * ys[pb];
    assign bwd  = xs[pb] * ys[pa];
    assign term = $signed(area_t'(fwd)) - $signed(area_t'(bwd));

    // sign depends on winding direction
    assign mag       = acc_q[`GF_AREA_W-1] ? area_t'(-acc_q) : area_t'(acc_q);
    assign poly_area = mag >> 1;
    assign poly_done = busy_q && (k_q == LAST);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            busy_q <= 1'b0;
            k_q    <= '0;
        end else if (area_start) begin
            busy_q <= 1'b1;
            k_q    <= '0;
        end else if (busy_q) begin
            busy_q <= (k_q != LAST);
            k_q    <= k_next;
        end
    end

    always_ff @(posedge clk) begin
        if (area_start) begin
            acc_q <= '0;
        end else if (busy_q) begin
            acc_q <= acc_q + term;
        end
    end

endmodule

// File: run.sh
#!/bin/sh
# builds the geofence testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

build_log=build.log
sim_log=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module geofence_tb \
    -f list.f -o geofence_sim > "$build_log" 2>&1
if [ $? -ne 0 ]; then
    cat "$build_log"
    echo "verilator build failed"
    exit 1
fi

./obj_dir/geofence_sim > "$sim_log" 2>&1
sim_status=$?
cat "$sim_log"

if grep -q "Simulation FAILED" "$sim_log"; then
    exit 1
fi
if [ $sim_status -ne 0 ]; then
    echo "simulator exited with status $sim_status"
    exit 1
fi
if ! grep -q "Simulation PASSED" "$sim_log"; then
    echo "simulation ended without a result"
    exit 1
fi
exit 0

// File: sim/geofence_properties.sv
`timescale 1ns/1ps

module geofence_properties (
    input logic clk,
    input logic reset,
    input logic valid,
    input logic is_inside,
    input logic sort_start,
    input logic area_start
);

    // cycles since reset, saturating
    logic [5:0] since_reset;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            since_reset <= '0;
        end else if (since_reset != 6'h3f) begin
            since_reset <= since_reset + 1'b1;
        end
    end

    // six captures and the whole sort come before any result
    quiet_after_reset: assert property (
        @(posedge clk) disable iff (reset)
        (since_reset < 6'd31) |-> (!valid && !is_inside)
    ) else $error("valid or is_inside high too soon after reset");

    // sort cannot start before the sixth capture
    starts_after_reset: assert property (
        @(posedge clk) disable iff (reset)
        (since_reset < 6'd5) |-> (!sort_start && !area_start)
    ) else $error("start pulse too soon after reset");

    valid_single_cycle: assert property (
        @(posedge clk) disable iff (reset)
        valid |=> !valid
    ) else $error("valid held for more than one cycle");

    inside_needs_valid: assert property (
        @(posedge clk) disable iff (reset)
        !valid |-> !is_inside
    ) else $error("is_inside high without valid");

endmodule

// File: sim/geofence_tb.sv
`timescale 1ns/1ps
`include "geofence_params.svh"

module geofence_tb import geofence_pkg::*; ();

    localparam int N_RANDOM       = 10;
    localparam int N_SHUFFLED     = 2;
    localparam int CYCLES_PER_SET = 200;
    // random sets, shuffle pairs, then the aborted set and the one after it
    localparam int TOTAL_SETS     = N_RANDOM + 2 * N_SHUFFLED + 2;
    localparam real PI            = 3.14159265358979;

    logic   clk;
    logic   reset;
    coord_t x;
    coord_t y;
    dist_t  r;
    logic   valid;
    logic   is_inside;

    int unsigned rng_state;
    int base_x [`GF_POINTS];
    int base_y [`GF_POINTS];
    int obj_x;
    int obj_y;
    int px [`GF_POINTS];
    int py [`GF_POINTS];
    int pr [`GF_POINTS];
    int seen_inside;
    int seen_outside;
    int first_px [`GF_POINTS];
    int first_py [`GF_POINTS];

    geofence dut_i (
        .clk       (clk),
        .reset     (reset),
        .x         (x),
        .y         (y),
        .r         (r),
        .valid     (valid),
        .is_inside (is_inside)
    );

    bind geofence geofence_properties props_i (
        .clk        (clk),
        .reset      (reset),
        .valid      (valid),
        .is_inside  (is_inside),
        .sort_start (sort_start),
        .area_start (area_start)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic int rand_below(input int unsigned n);
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return int'((rng_state >> 8) % n);
    endfunction

    // floor of the root, zero for a negative radicand
    function automatic longint floor_sqrt(input longint n);
        longint lo;
        longint hi;
        longint mid;
        lo = 0;
        hi = 4096;
        if (n <= 0) begin
            return 0;
        end
        while (hi - lo > 1) begin
            mid = (lo + hi) / 2;
            if (mid * mid <= n) begin
                lo = mid;
            end else begin
                hi = mid;
            end
        end
        return lo;
    endfunction

    // hexagon with 60 degree steps, object near the center or at twice the radius
    task automatic make_hexagon(input bit exterior);
        int  cx;
        int  cy;
        int  rad;
        int  rot;
        int  d;
        real ang;
        cx  = 400 + rand_below(200);
        cy  = 400 + rand_below(200);
        rad = 120 + rand_below(120);
        rot = rand_below(60);
        for (int k = 0; k < `GF_POINTS; k++) begin
            ang = (rot + 60 * k) * PI / 180.0;
            base_x[k] = cx + $rtoi(rad * $cos(ang));
            base_y[k] = cy + $rtoi(rad * $sin(ang));
        end
        if (exterior) begin
            ang   = rand_below(360) * PI / 180.0;
            obj_x = cx + $rtoi(2.0 * rad * $cos(ang));
            obj_y = cy + $rtoi(2.0 * rad * $sin(ang));
        end else begin
            d     = rad / 4;
            obj_x = cx + rand_below(2 * d + 1) - d;
            obj_y = cy + rand_below(2 * d + 1) - d;
        end
    endtask

    // point 0 stays first, points 1 to 5 are permuted
    task automatic apply_shuffle();
        int     perm [`GF_POINTS];
        int     j;
        int     tmp;
        longint ddx;
        longint ddy;
        for (int k = 0; k < `GF_POINTS; k++) begin
            perm[k] = k;
        end
        for (int k = `GF_POINTS - 1; k > 1; k--) begin
            j       = 1 + rand_below(k);
            tmp     = perm[k];
            perm[k] = perm[j];
            perm[j] = tmp;
        end
        for (int k = 0; k < `GF_POINTS; k++) begin
            px[k] = base_x[perm[k]];
            py[k] = base_y[perm[k]];
            ddx   = px[k] - obj_x;
            ddy   = py[k] - obj_y;
            pr[k] = int'(floor_sqrt(ddx * ddx + ddy * ddy));
        end
    endtask

    // true while points 1 to 5 repeat the saved order
    function automatic bit same_as_first();
        for (int k = 1; k < `GF_POINTS; k++) begin
            if (px[k] != first_px[k] || py[k] != first_py[k]) begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    function automatic bit model_inside();
        int     ord [`GF_POINTS];
        int     cnt;
        int     a;
        int     b;
        longint xprod;
        longint shoe;
        longint tri_sum;
        longint ddx;
        longint ddy;
        longint c;
        longint s;
        ord[0] = 0;
        for (int i = 1; i < `GF_POINTS; i++) begin
            cnt = 0;
            for (int j = 1; j < `GF_POINTS; j++) begin
                xprod = longint'(px[i] - px[0]) * (py[j] - py[0])
                      - longint'(px[j] - px[0]) * (py[i] - py[0]);
                if (xprod < 0) begin
                    cnt++;
                end
            end
            ord[1 + cnt] = i;
        end
        shoe    = 0;
        tri_sum = 0;
        for (int k = 0; k < `GF_POINTS; k++) begin
            a       = ord[k];
            b       = ord[(k + 1) % `GF_POINTS];
            shoe    += longint'(px[a]) * py[b] - longint'(px[b]) * py[a];
            ddx     = px[a] - px[b];
            ddy     = py[a] - py[b];
            c       = floor_sqrt(ddx * ddx + ddy * ddy);
            s       = (c + pr[a] + pr[b]) / 2;
            tri_sum += floor_sqrt(s * (s - c)) * floor_sqrt((s - pr[a]) * (s - pr[b]));
        end
        if (shoe < 0) begin
            shoe = -shoe;
        end
        return tri_sum < shoe / 2;
    endfunction

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("Simulation FAILED");
        $fatal(1);
    endtask

    // caller sits on the falling edge where point 0 goes out
    task automatic drive_points();
        for (int k = 0; k < `GF_POINTS; k++) begin
            x = coord_t'(px[k]);
            y = coord_t'(py[k]);
            r = dist_t'(pr[k]);
            @(negedge clk);
        end
    endtask

    task automatic run_set(input string name);
        bit expected;
        int waited;
        expected = model_inside();
        drive_points();
        waited = 0;
        while (!valid) begin
            assert (waited < CYCLES_PER_SET)
            else stop_with_failure($sformatf("no valid pulse for %s", name));
            @(negedge clk);
            waited++;
        end
        assert (is_inside == expected)
        else stop_with_failure($sformatf("mismatch %s: expected %0b, actual %0b",
                                         name, expected, is_inside));
        if (is_inside) begin
            seen_inside++;
        end else begin
            seen_outside++;
        end
        @(negedge clk);
    endtask

    initial begin
        rng_state    = 32'h3e8a_3a10;
        seen_inside  = 0;
        seen_outside = 0;
        reset        = 1'b1;
        x            = '0;
        y            = '0;
        r            = '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        // back to back, each set starts right after the previous valid
        for (int n = 0; n < N_RANDOM; n++) begin
            make_hexagon(n % 2 == 1);
            apply_shuffle();
            run_set($sformatf("random %0d", n));
        end

        for (int n = 0; n < N_SHUFFLED; n++) begin
            make_hexagon(n == 0);
            apply_shuffle();
            run_set($sformatf("shuffle %0d first order", n));
            first_px = px;
            first_py = py;
            apply_shuffle();
            while (same_as_first()) begin
                apply_shuffle();
            end
            run_set($sformatf("shuffle %0d second order", n));
        end

        // cut a computation short, the set after reset must still be right
        make_hexagon(1'b1);
        apply_shuffle();
        drive_points();
        repeat (40) begin
            assert (!valid)
            else stop_with_failure("valid rose before the mid-computation reset");
            @(negedge clk);
        end
        reset = 1'b1;
        repeat (2) @(negedge clk);
        reset = 1'b0;
        make_hexagon(1'b0);
        apply_shuffle();
        run_set("after reset");

        if (seen_inside == 0 || seen_outside == 0) begin
            stop_with_failure("only one of the two decisions was ever produced");
        end else begin
            $display("Simulation PASSED");
            $finish;
        end
    end

    initial begin
        #(TOTAL_SETS * CYCLES_PER_SET * 100);
        stop_with_failure("watchdog expired before all sets completed");
    end

endmodule
